/* i2c_bus_pkg.sv */
`default_nettype none

package i2c_bus_pkg;

    // ============================================================
    // wire-level types
    // ============================================================
    typedef logic [7:0] byte_t;        // one byte as shifted on sda
    typedef logic [5:0] tick_idx_t;    // quarter ticks seen in one bus op

    typedef enum logic [2:0] {
        op_start   = 3'd0,
        op_write   = 3'd1,
        op_read    = 3'd2,
        op_restart = 3'd3,
        op_stop    = 3'd4
    } bus_op_e;

    // ============================================================
    // phase constants
    // ============================================================
    localparam int quarters_per_bit = 4;
    localparam int bits_per_byte    = 8;
    localparam int cond_len         = 4;     // start, restart or stop
    localparam int byte_len         = 36;    // eight data bits plus ack

endpackage

`default_nettype wire

/* i2c_txn_pkg.sv */
`default_nettype none

package i2c_txn_pkg;

    import i2c_bus_pkg::byte_t;

    // ============================================================
    // register access command and response
    // ============================================================
    typedef logic [6:0] dev_addr_t;
    typedef logic [7:0] reg_addr_t;

    typedef struct packed {
        logic      rd;          // 1 = register read
        dev_addr_t dev_addr;
        reg_addr_t reg_addr;
        byte_t     wdata;       // ignored on reads
    } i2c_cmd_t;

    typedef struct packed {
        byte_t rdata;           // zero for writes
        logic  nack;            // some byte was not acknowledged
    } i2c_resp_t;

    // one state per bus operation of the transaction
    typedef enum logic [3:0] {
        st_idle    = 4'd0,
        st_start   = 4'd1,
        st_dev_wr  = 4'd2,
        st_reg     = 4'd3,
        st_wdata   = 4'd4,
        st_restart = 4'd5,
        st_dev_rd  = 4'd6,
        st_rdata   = 4'd7,
        st_stop    = 4'd8
    } master_state_e;

endpackage

`default_nettype wire

/* i2c_quarter_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_quarter_timer
    import i2c_bus_pkg::*;
#(
    parameter int clk_div = 25               // clk cycles per quarter scl period
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      run,
    output logic      tick,
    output tick_idx_t tick_idx
);

    localparam int div_w = $clog2(clk_div);

    logic [div_w-1:0] div_cnt;
    logic             div_end;

    assign div_end = (div_cnt == div_w'(clk_div - 1));
    assign tick    = run && div_end;          // first tick clk_div cycles after run

    // ============================================================
    // clock divider
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (!run) begin
            div_cnt <= '0;                    // restart phase for every op
        end else if (div_end) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ============================================================
    // tick counter
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_idx <= '0;
        end else if (!run) begin
            tick_idx <= '0;
        end else if (tick) begin
            tick_idx <= tick_idx + 1'b1;      // index of the next tick
        end
    end

endmodule

`default_nettype wire

/* i2c_bit_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine
    import i2c_bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // operation request from the master fsm
    input  logic      op_go,
    input  bus_op_e   op,
    input  byte_t     op_byte,
    output logic      op_done,
    output logic      ack_ok,
    output byte_t     rx_byte,
    // quarter timer
    output logic      run,
    input  logic      tick,
    input  tick_idx_t tick_idx,
    // open drain bus
    output logic      scl,
    output logic      sda_oe,
    input  logic      sda_in
);

    // quarter numbers inside a bit
    localparam logic [1:0] q_high = 2'd0;    // scl high, sda edges of conditions
    localparam logic [1:0] q_fall = 2'd1;    // scl falls, slave bits sampled
    localparam logic [1:0] q_data = 2'd2;    // scl low, sda may change
    localparam logic [1:0] q_rise = 2'd3;
    localparam logic [3:0] data_bits = 4'(bits_per_byte);

    bus_op_e    op_q;
    byte_t      shift_q;
    logic [3:0] bit_idx;
    logic [1:0] quarter;
    logic       is_cond;
    logic       data_bit;
    tick_idx_t  last_idx;
    logic       last_tick;

    // ============================================================
    // position within the current operation
    // ============================================================
    // every op opens in the low half of scl, so its first tick is quarter 2
    assign bit_idx   = 4'(tick_idx / quarters_per_bit);
    assign quarter   = 2'(tick_idx % quarters_per_bit) + 2'd2;
    assign data_bit  = (bit_idx < data_bits);    // bit 8 is the ack slot
    assign is_cond   = (op_q == op_start) || (op_q == op_restart) || (op_q == op_stop);
    assign last_idx  = is_cond ? tick_idx_t'(cond_len - 1) : tick_idx_t'(byte_len - 1);
    assign last_tick = tick && (tick_idx == last_idx);
    assign rx_byte   = shift_q;

    // ============================================================
    // op control
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op_q    <= op_start;
            run     <= 1'b0;
            op_done <= 1'b0;
            ack_ok  <= 1'b0;
        end else begin
            op_done <= 1'b0;
            if (op_go) begin
                op_q <= op;
                run  <= 1'b1;
            end else if (last_tick) begin
                run     <= 1'b0;
                op_done <= 1'b1;
                ack_ok  <= (op_q == op_write) && !sda_in;   // ack slot still high
            end
        end
    end

    // ============================================================
    // shift register
    // ============================================================
    always_ff @(posedge clk) begin
        if (op_go) begin
            shift_q <= op_byte;
        end else if (tick && data_bit) begin
            if (op_q == op_write && quarter == q_data) begin
                shift_q <= {shift_q[6:0], 1'b0};            // msb first
            end else if (op_q == op_read && quarter == q_fall) begin
                shift_q <= {shift_q[6:0], sda_in};
            end
        end
    end

    // ============================================================
    // scl and sda drive
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scl    <= 1'b1;
            sda_oe <= 1'b0;
        end else if (tick) begin
            case (quarter)
                q_data: begin
                    case (op_q)
                        op_write: sda_oe <= data_bit ? !shift_q[7] : 1'b0;
                        op_stop:  sda_oe <= 1'b1;           // low before scl rises
                        default:  sda_oe <= 1'b0;           // release, also read nack
                    endcase
                end
                q_rise: begin
                    scl <= 1'b1;
                end
                q_high: begin
                    if (is_cond) begin
                        sda_oe <= (op_q != op_stop);        // fall = start, rise = stop
                    end
                end
                default: begin                              // q_fall
                    if (op_q != op_stop) begin
                        scl <= 1'b0;                        // bus stays idle after stop
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* i2c_master_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master_fsm
    import i2c_bus_pkg::*;
    import i2c_txn_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    // command and response
    input  logic      cmd_valid,
    output logic      cmd_ready,
    input  i2c_cmd_t  cmd,
    output logic      resp_valid,
    output i2c_resp_t resp,
    // bit engine
    output logic      op_go,
    output bus_op_e   op,
    output byte_t     op_byte,
    input  logic      op_done,
    input  logic      ack_ok,
    input  byte_t     rx_byte
);

    master_state_e state;
    i2c_cmd_t      cmd_q;
    byte_t         rdata_q;
    logic          nack_q;

    assign cmd_ready = (state == st_idle);

    // ============================================================
    // operation and byte for the current state
    // ============================================================
    always_comb begin
        op      = op_write;
        op_byte = '0;
        case (state)
            st_start:   op = op_start;
            st_dev_wr:  op_byte = {cmd_q.dev_addr, 1'b0};
            st_reg:     op_byte = cmd_q.reg_addr;
            st_wdata:   op_byte = cmd_q.wdata;
            st_restart: op = op_restart;
            st_dev_rd:  op_byte = {cmd_q.dev_addr, 1'b1};
            st_rdata:   op = op_read;
            st_stop:    op = op_stop;
            default:    op = op_write;              // idle, never issued
        endcase
    end

    // ============================================================
    // transaction sequencing
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            nack_q     <= 1'b0;
            op_go      <= 1'b0;
            resp_valid <= 1'b0;
            resp       <= '0;
        end else begin
            op_go      <= 1'b0;
            resp_valid <= 1'b0;
            if (state == st_idle) begin
                if (cmd_valid) begin
                    nack_q <= 1'b0;
                    state  <= st_start;
                    op_go  <= 1'b1;
                end
            end else if (op_done) begin
                op_go <= 1'b1;                      // cleared again below for stop
                case (state)
                    st_start: state <= st_dev_wr;
                    st_dev_wr, st_dev_rd: begin
                        if (!ack_ok) begin
                            nack_q <= 1'b1;
                            state  <= st_stop;
                        end else begin
                            state <= (state == st_dev_wr) ? st_reg : st_rdata;
                        end
                    end
                    st_reg: begin
                        if (!ack_ok) begin
                            nack_q <= 1'b1;
                            state  <= st_stop;
                        end else begin
                            state <= cmd_q.rd ? st_restart : st_wdata;
                        end
                    end
                    st_wdata: begin
                        nack_q <= !ack_ok;
                        state  <= st_stop;
                    end
                    st_restart: state <= st_dev_rd;
                    st_rdata:   state <= st_stop;
                    default: begin                  // st_stop done
                        op_go       <= 1'b0;
                        state       <= st_idle;
                        resp_valid  <= 1'b1;
                        resp.rdata  <= rdata_q;
                        resp.nack   <= nack_q;
                    end
                endcase
            end
        end
    end

    // ============================================================
    // command and read data capture
    // ============================================================
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cmd_q   <= cmd;
            rdata_q <= '0;                          // writes report zero
        end else if (op_done && state == st_rdata) begin
            rdata_q <= rx_byte;
        end
    end

endmodule

`default_nettype wire

/* i2c_master.sv */
`timescale 1ns/1ps
`default_nettype none

module i2c_master
    import i2c_bus_pkg::*;
    import i2c_txn_pkg::*;
#(
    parameter int clk_div = 25               // clk cycles per quarter scl period
) (
    input  logic      clk,
    input  logic      rst_n,
    // command and response
    input  logic      cmd_valid,
    output logic      cmd_ready,
    input  i2c_cmd_t  cmd,
    output logic      resp_valid,
    output i2c_resp_t resp,
    // open drain bus
    output logic      scl,
    output logic      sda_oe,
    input  logic      sda_in
);

    // fsm to bit engine
    logic      op_go;
    bus_op_e   op;
    byte_t     op_byte;
    logic      op_done;
    logic      ack_ok;
    byte_t     rx_byte;

    // bit engine to timer
    logic      run;
    logic      tick;
    tick_idx_t tick_idx;

    i2c_master_fsm u_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd        (cmd),
        .resp_valid (resp_valid),
        .resp       (resp),
        .op_go      (op_go),
        .op         (op),
        .op_byte    (op_byte),
        .op_done    (op_done),
        .ack_ok     (ack_ok),
        .rx_byte    (rx_byte)
    );

    i2c_bit_engine u_engine (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_go    (op_go),
        .op       (op),
        .op_byte  (op_byte),
        .op_done  (op_done),
        .ack_ok   (ack_ok),
        .rx_byte  (rx_byte),
        .run      (run),
        .tick     (tick),
        .tick_idx (tick_idx),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

    i2c_quarter_timer #(
        .clk_div (clk_div)
    ) u_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .run      (run),
        .tick     (tick),
        .tick_idx (tick_idx)
    );

endmodule

`default_nettype wire

/* tb_i2c_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_slave
    import i2c_bus_pkg::*;
#(
    parameter logic [6:0]  dev_addr = 7'h50,
    parameter logic [31:0] reg_seed = 32'h3557_2fce
) (
    input  logic rst_n,
    input  logic scl,
    input  logic sda,
    output logic sda_drv,                        // 0 pulls the line low
    output logic framing_err                     // start or stop inside a byte
);

    byte_t  regs [256];
    byte_t  rx_q;
    byte_t  tx_q;
    byte_t  reg_ptr;
    int     bit_cnt;                             // scl rises seen in this byte
    int     byte_no;                             // bytes since start or restart
    logic   selected;
    logic   reading;
    logic   master_ack;
    logic   scl_q;
    logic   sda_q;
    integer seed;

    initial begin
        seed = reg_seed;
        for (int i = 0; i < 256; i++) begin
            regs[i] = byte_t'($random(seed));
        end
        sda_drv     = 1'b1;
        framing_err = 1'b0;
        bit_cnt     = 0;
        byte_no     = 0;
        selected    = 1'b0;
        reading     = 1'b0;
        scl_q       = 1'b1;
        sda_q       = 1'b1;
        forever begin
            @(scl or sda);
            // ====================================================
            // sda edge with scl high: start, restart or stop
            // ====================================================
            if (rst_n && scl && scl_q && (sda != sda_q)) begin
                if (bit_cnt > 1) begin
                    framing_err = 1'b1;
                end
                bit_cnt  = 0;
                byte_no  = 0;
                selected = 1'b0;
                reading  = 1'b0;
                sda_drv  = 1'b1;
            end else if (rst_n && scl && !scl_q) begin
                bit_cnt = bit_cnt + 1;
                if (bit_cnt <= bits_per_byte) begin
                    rx_q = {rx_q[6:0], sda};     // msb first
                end else begin
                    master_ack = !sda;           // ninth bit
                end
            end else if (rst_n && !scl && scl_q) begin
                if (bit_cnt == bits_per_byte && !reading) begin
                    if (byte_no == 0) begin
                        selected = (rx_q[7:1] == dev_addr);
                        reading  = rx_q[0];
                    end else if (selected && byte_no == 1) begin
                        reg_ptr = rx_q;
                    end else if (selected) begin
                        regs[reg_ptr] = rx_q;
                        reg_ptr       = reg_ptr + 8'd1;
                    end
                    sda_drv = !selected;         // ack only when addressed
                end else if (bit_cnt == bits_per_byte + 1) begin
                    bit_cnt = 0;
                    byte_no = byte_no + 1;
                    sda_drv = 1'b1;
                    if (selected && reading && (byte_no == 1 || master_ack)) begin
                        tx_q    = regs[reg_ptr];
                        reg_ptr = reg_ptr + 8'd1;
                        sda_drv = tx_q[7];
                    end
                end else if (selected && reading) begin
                    sda_drv = (bit_cnt < bits_per_byte) ? tx_q[7 - bit_cnt] : 1'b1;
                end
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

`default_nettype wire

/* tb_i2c_master.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_master
    import i2c_bus_pkg::*;
    import i2c_txn_pkg::*;
();

    localparam int          clk_div    = 4;
    localparam int          wait_limit = 2000;          // clk cycles, a read needs about 640
    localparam int          n_rows     = 9;
    localparam logic [31:0] reg_seed   = 32'h3557_2fce;

    typedef struct packed {
        i2c_cmd_t  cmd;
        i2c_resp_t exp;
    } row_t;

    logic      clk = 1'b0;
    logic      rst_n;
    logic      cmd_valid;
    logic      cmd_ready;
    i2c_cmd_t  cmd;
    logic      resp_valid;
    i2c_resp_t resp;
    logic      scl;
    logic      sda_oe;
    logic      sda_line;
    logic      slave_sda;
    logic      framing_err;
    byte_t     preset [256];                            // slave contents at power up
    row_t      rows [n_rows];
    integer    seed;
    int        resp_count;

    assign sda_line = !sda_oe && slave_sda;             // open drain with pull-up

    i2c_master #(
        .clk_div (clk_div)
    ) u_i2c_master (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd        (cmd),
        .resp_valid (resp_valid),
        .resp       (resp),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_in     (sda_line)
    );

    tb_i2c_slave #(
        .dev_addr (7'h50),
        .reg_seed (reg_seed)
    ) u_slave (
        .rst_n       (rst_n),
        .scl         (scl),
        .sda         (sda_line),
        .sda_drv     (slave_sda),
        .framing_err (framing_err)
    );

    always #2 clk = ~clk;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_count <= 0;
        end else if (resp_valid) begin
            resp_count <= resp_count + 1;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // ============================================================
    // one table row: handshake, wait for response, check
    // ============================================================
    task automatic run_row(input int r);
        row_t row;
        int   waited;
        row    = rows[r];
        waited = 0;
        while (!cmd_ready) begin
            @(negedge clk);
            waited++;
            if (waited > wait_limit) fail_run($sformatf("row %0d: cmd_ready never rose", r));
        end
        cmd_valid = 1'b1;
        cmd       = row.cmd;
        @(negedge clk);
        cmd_valid = 1'b0;
        waited    = 0;
        while (!resp_valid) begin
            assert (!cmd_ready)
                else fail_run($sformatf("Mismatch at %0d ns: row %0d ready while busy", $time, r));
            @(negedge clk);
            waited++;
            if (waited > wait_limit) fail_run($sformatf("row %0d: no response arrived", r));
        end
        assert (resp == row.exp)
            else fail_run($sformatf("Mismatch at %0d ns: row %0d got nack %0b rdata %02h, %s",
                                    $time, r, resp.nack, resp.rdata,
                                    $sformatf("expected nack %0b rdata %02h",
                                              row.exp.nack, row.exp.rdata)));
        assert (scl && !sda_oe)
            else fail_run($sformatf("Mismatch at %0d ns: row %0d bus not idle", $time, r));
        assert (!framing_err)
            else fail_run($sformatf("row %0d: slave saw a start or stop inside a byte", r));
        @(negedge clk);
        assert (!resp_valid && resp_count == r + 1)
            else fail_run($sformatf("Mismatch at %0d ns: row %0d response count %0d",
                                    $time, r, resp_count));
    endtask

    initial begin
        seed = reg_seed;
        for (int i = 0; i < 256; i++) begin
            preset[i] = byte_t'($random(seed));
        end
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        // rd, device, register, wdata / expected rdata, nack
        rows[0] = '{'{1'b0, 7'h50, 8'h12, 8'ha5}, '{8'h00, 1'b0}};
        rows[1] = '{'{1'b1, 7'h50, 8'h12, 8'h00}, '{8'ha5, 1'b0}};
        rows[2] = '{'{1'b1, 7'h50, 8'h3c, 8'h00}, '{preset[8'h3c], 1'b0}};
        rows[3] = '{'{1'b0, 7'h21, 8'h05, 8'h77}, '{8'h00, 1'b1}};   // no such device
        rows[4] = '{'{1'b1, 7'h50, 8'h05, 8'h00}, '{preset[8'h05], 1'b0}};
        rows[5] = '{'{1'b1, 7'h21, 8'h80, 8'h00}, '{8'h00, 1'b1}};
        rows[6] = '{'{1'b0, 7'h50, 8'h3c, 8'h5a}, '{8'h00, 1'b0}};
        rows[7] = '{'{1'b1, 7'h50, 8'h3c, 8'h00}, '{8'h5a, 1'b0}};
        rows[8] = '{'{1'b1, 7'h50, 8'hff, 8'h00}, '{preset[8'hff], 1'b0}};
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (scl && !sda_oe)
            else fail_run($sformatf("Mismatch at %0d ns: bus not idle after reset", $time));
        assert (cmd_ready && !resp_valid)
            else fail_run($sformatf("Mismatch at %0d ns: handshake wrong after reset", $time));
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* i2c_master.f */
i2c_bus_pkg.sv
i2c_txn_pkg.sv
i2c_quarter_timer.sv
i2c_bit_engine.sv
i2c_master_fsm.sv
i2c_master.sv
tb_i2c_slave.sv
tb_i2c_master.sv

/* Makefile */
# Verilator build and run of the I2C master testbench

VERILATOR ?= verilator
TOP       ?= tb_i2c_master
FILELIST  ?= i2c_master.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
